//--- common/ifu_pkg.sv
package ifu_pkg;

  // ##########################################################################
  // widths and cache geometry
  // ##########################################################################

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam int L1I_SETS = 4;
  localparam int IDX_W = 2;
  localparam int LINE_WORDS = 2;
  localparam int OFF_W = 1;
  localparam int TAG_W = 27;              // address bits 31 down to 5.

  // lines in this window are fetched with a single burst request.
  localparam logic [ADDR_W-1:0] BURST_LO = 32'ha000_0000;
  localparam logic [ADDR_W-1:0] BURST_HI = 32'hc000_0000;

  // ##########################################################################
  // rv32 opcodes that end sequential fetch
  // ##########################################################################

  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [DATA_W-1:0] INST_FENCE_I = 32'h0000_100f;

  // refill sequencer states.
  localparam logic [1:0] RF_IDLE = 2'd0;
  localparam logic [1:0] RF_WORD0 = 2'd1;
  localparam logic [1:0] RF_GAP = 2'd2;
  localparam logic [1:0] RF_WORD1 = 2'd3;

  // ##########################################################################
  // fetch address, seen as a bus word or as cache fields
  // ##########################################################################

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] off;
    logic [1:0]       byte_off;
  } fetch_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    fetch_fields_t     f;
  } fetch_addr_u;

endpackage

//--- design/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [ifu_pkg::ADDR_W-1:0] pc_i,
  input  logic                      pc_valid_i,
  output logic                      pc_ready_o,
  input  logic                      handoff_i,
  input  logic                      ctrl_i,
  output logic [ifu_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                      lookup_o
);

  import ifu_pkg::*;

  logic              busy_q;             // high while fetching, low while idle.
  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_next;

  assign pc_next = pc_q + 32'd4;

  // ##########################################################################
  // idle / fetching sequencer
  // ##########################################################################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (pc_valid_i)
      begin
        busy_q <= 1'b1;
      end
    end
    else if (handoff_i && ctrl_i)
    begin
      busy_q <= 1'b0;                    // wait for a new target from upstream.
    end
  end

  always_ff @(posedge clk)
  begin
    if (!busy_q && pc_valid_i)
    begin
      pc_q <= pc_i;
    end
    else if (busy_q && handoff_i && !ctrl_i)
    begin
      pc_q <= pc_next;
    end
  end

  assign pc_ready_o = !busy_q;
  assign fetch_addr_o = pc_q;

  // the cache only hits while decode has room, so a level is enough here.
  assign lookup_o = busy_q;

endmodule

//--- l1i/l1i_cache.sv
`timescale 1ns/1ps

module l1i_cache (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [ifu_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                      lookup_i,
  input  logic                      accept_i,
  input  logic                      flush_i,
  output logic                      hit_o,
  output logic [ifu_pkg::DATA_W-1:0] hit_inst_o,
  output logic                      miss_o,
  output logic [ifu_pkg::ADDR_W-1:0] miss_addr_o,
  input  logic                      wr_i,
  input  logic [ifu_pkg::OFF_W-1:0]  wr_off_i,
  input  logic [ifu_pkg::DATA_W-1:0] wr_data_i,
  input  logic                      wr_last_i
);

  import ifu_pkg::*;

  // ##########################################################################
  // storage
  // ##########################################################################

  logic [DATA_W-1:0]   data_q [L1I_SETS][LINE_WORDS];
  logic [TAG_W-1:0]    tag_q [L1I_SETS];
  logic [L1I_SETS-1:0] valid_q;

  fetch_addr_u fa;
  fetch_addr_u line_base;
  logic        tag_match;

  assign fa.raw = fetch_addr_i;

  // ##########################################################################
  // lookup
  // ##########################################################################

  assign tag_match = valid_q[fa.f.idx] && (tag_q[fa.f.idx] == fa.f.tag);

  // a hit is only reported when the output stage can take it.
  assign hit_o = lookup_i && accept_i && tag_match;
  assign hit_inst_o = data_q[fa.f.idx][fa.f.off];

  // stays high through the whole refill, until the last word lands.
  assign miss_o = lookup_i && !tag_match;

  always_comb
  begin
    line_base = fa;
    line_base.f.off = '0;
    line_base.f.byte_off = 2'b00;
  end

  assign miss_addr_o = line_base.raw;

  // ##########################################################################
  // line writes
  // ##########################################################################

  // the fetch pc is held during a refill, so it still names the line.
  always_ff @(posedge clk)
  begin
    if (wr_i)
    begin
      data_q[fa.f.idx][wr_off_i] <= wr_data_i;
    end
    if (wr_last_i)
    begin
      tag_q[fa.f.idx] <= fa.f.tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;                     // fence.i drops every line.
    end
    else if (wr_last_i)
    begin
      valid_q[fa.f.idx] <= 1'b1;
    end
  end

endmodule

//--- l1i/l1i_refill.sv
`timescale 1ns/1ps

module l1i_refill (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      miss_i,
  input  logic [ifu_pkg::ADDR_W-1:0] miss_addr_i,
  output logic [ifu_pkg::ADDR_W-1:0] araddr_o,
  output logic                      arvalid_o,
  output logic                      arburst_o,
  input  logic [ifu_pkg::DATA_W-1:0] rdata_i,
  input  logic                      rvalid_i,
  output logic                      wr_o,
  output logic [ifu_pkg::OFF_W-1:0]  wr_off_o,
  output logic [ifu_pkg::DATA_W-1:0] wr_data_o,
  output logic                      wr_last_o
);

  import ifu_pkg::*;

  logic [1:0]  state_q;
  fetch_addr_u base_q;                   // line base, word offset zero.
  logic        burst_q;
  logic        in_window;
  fetch_addr_u req_addr;

  assign in_window = (miss_addr_i >= BURST_LO) && (miss_addr_i <= BURST_HI);

  // ##########################################################################
  // line fetch sequencer
  // ##########################################################################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= RF_IDLE;
    end
    else
    begin
      case (state_q)
        RF_IDLE:
          if (miss_i)
          begin
            state_q <= RF_WORD0;
          end
        RF_WORD0:
          if (rvalid_i)
          begin
            state_q <= burst_q ? RF_WORD1 : RF_GAP;
          end
        RF_GAP:
          state_q <= RF_WORD1;           // one idle cycle between single reads.
        default:
          if (rvalid_i)
          begin
            state_q <= RF_IDLE;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == RF_IDLE && miss_i)
    begin
      base_q.raw <= miss_addr_i;
      burst_q <= in_window;
    end
  end

  // ##########################################################################
  // bus request and line write
  // ##########################################################################

  always_comb
  begin
    req_addr = base_q;
    req_addr.f.off = (state_q == RF_WORD0) ? 1'b0 : 1'b1;
  end

  assign araddr_o = req_addr.raw;
  assign arvalid_o = (state_q == RF_WORD0) || (state_q == RF_WORD1 && !burst_q);
  assign arburst_o = arvalid_o && burst_q;

  assign wr_o = rvalid_i && (state_q == RF_WORD0 || state_q == RF_WORD1);
  assign wr_off_o = (state_q == RF_WORD1) ? 1'b1 : 1'b0;
  assign wr_data_o = rdata_i;
  assign wr_last_o = rvalid_i && (state_q == RF_WORD1);

endmodule

//--- design/fetch_out.sv
`timescale 1ns/1ps

module fetch_out (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      hit_i,
  input  logic [ifu_pkg::DATA_W-1:0] hit_inst_i,
  input  logic [ifu_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                      next_ready_i,
  output logic [ifu_pkg::DATA_W-1:0] inst_o,
  output logic [ifu_pkg::ADDR_W-1:0] pc_o,
  output logic                      valid_o,
  output logic                      accept_o,
  output logic                      handoff_o,
  output logic                      ctrl_o,
  output logic                      flush_o
);

  import ifu_pkg::*;

  logic              valid_q;
  logic [DATA_W-1:0] inst_q;
  logic [ADDR_W-1:0] pc_q;
  logic              flush_q;
  logic [6:0]        opcode;
  logic              is_fence_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
      flush_q <= 1'b0;
    end
    else
    begin
      if (!valid_q && hit_i)
      begin
        valid_q <= 1'b1;
      end
      else if (handoff_o)
      begin
        valid_q <= 1'b0;
      end
      flush_q <= handoff_o && is_fence_i;   // one cycle, right after the handoff.
    end
  end

  always_ff @(posedge clk)
  begin
    if (!valid_q && hit_i)
    begin
      inst_q <= hit_inst_i;
      pc_q <= fetch_addr_i;
    end
  end

  // predecode of the held word.
  assign opcode = inst_q[6:0];
  assign is_fence_i = (inst_q == INST_FENCE_I);
  assign ctrl_o = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH) ||
                  (opcode == OP_SYSTEM) || is_fence_i;

  assign handoff_o = valid_q && next_ready_i;
  assign accept_o = !valid_q;
  assign valid_o = valid_q;
  assign inst_o = inst_q;
  assign pc_o = pc_q;
  assign flush_o = flush_q;

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                      clk,
  input  logic                      rst,
  // upstream pc.
  input  logic [ifu_pkg::ADDR_W-1:0] pc_i,
  input  logic                      pc_valid_i,
  output logic                      pc_ready_o,
  // decode side.
  output logic [ifu_pkg::DATA_W-1:0] inst_o,
  output logic [ifu_pkg::ADDR_W-1:0] pc_o,
  output logic                      valid_o,
  input  logic                      next_ready_i,
  // read bus.
  output logic [ifu_pkg::ADDR_W-1:0] araddr_o,
  output logic                      arvalid_o,
  output logic                      arburst_o,
  input  logic [ifu_pkg::DATA_W-1:0] rdata_i,
  input  logic                      rvalid_i
);

  import ifu_pkg::*;

  logic [ADDR_W-1:0] fetch_addr;
  logic              lookup;
  logic              hit;
  logic [DATA_W-1:0] hit_inst;
  logic              miss;
  logic [ADDR_W-1:0] miss_addr;
  logic              wr;
  logic [OFF_W-1:0]  wr_off;
  logic [DATA_W-1:0] wr_data;
  logic              wr_last;
  logic              accept;
  logic              handoff;
  logic              ctrl;
  logic              flush;

  fetch_pc u_fetch_pc (
    .clk, .rst, .pc_i, .pc_valid_i, .pc_ready_o,
    .handoff_i(handoff), .ctrl_i(ctrl),
    .fetch_addr_o(fetch_addr), .lookup_o(lookup)
  );

  l1i_cache u_l1i_cache (
    .clk, .rst, .fetch_addr_i(fetch_addr), .lookup_i(lookup),
    .accept_i(accept), .flush_i(flush), .hit_o(hit), .hit_inst_o(hit_inst),
    .miss_o(miss), .miss_addr_o(miss_addr), .wr_i(wr), .wr_off_i(wr_off),
    .wr_data_i(wr_data), .wr_last_i(wr_last)
  );

  l1i_refill u_l1i_refill (
    .clk, .rst, .miss_i(miss), .miss_addr_i(miss_addr),
    .araddr_o, .arvalid_o, .arburst_o, .rdata_i, .rvalid_i,
    .wr_o(wr), .wr_off_o(wr_off), .wr_data_o(wr_data), .wr_last_o(wr_last)
  );

  fetch_out u_fetch_out (
    .clk, .rst, .hit_i(hit), .hit_inst_i(hit_inst), .fetch_addr_i(fetch_addr),
    .next_ready_i, .inst_o, .pc_o, .valid_o, .accept_o(accept),
    .handoff_o(handoff), .ctrl_o(ctrl), .flush_o(flush)
  );

endmodule

//--- tests/bus_mem_model.sv
`timescale 1ns/1ps

module bus_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        arvalid_i,
  input  logic [31:0] araddr_i,
  input  logic        arburst_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  output logic [31:0] mem_addr_o,
  input  logic [31:0] mem_data_i,
  input  logic        bp_en_i,
  output logic        next_ready_o,
  output int          req_count_o
);

  logic [15:0] lfsr_q;
  logic        busy_q;
  logic [1:0]  wait_q;
  int          words_left;

  assign rdata_o = mem_data_i;          // the testbench supplies the word at mem_addr_o.

  // galois lfsr, one step per bit taken.
  function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b)
    begin
      lfsr_q = lfsr_q ^ 16'hb400;
    end
    return b;
  endfunction

  function automatic logic [1:0] take_delay();
    logic [1:0] d;
    d[0] = take_bit();
    d[1] = take_bit();
    return d;
  endfunction

  // ##########################################################################
  // one step per clock, just after the rising edge
  // ##########################################################################

  task automatic model_cycle();
    rvalid_o = 1'b0;
    next_ready_o = bp_en_i ? take_bit() : 1'b1;
    if (!busy_q && !rst && arvalid_i)
    begin
      req_count_o = req_count_o + 1;
      mem_addr_o = araddr_i;
      words_left = arburst_i ? 2 : 1;
      wait_q = take_delay();
      busy_q = 1'b1;
    end
    if (busy_q)
    begin
      if (wait_q == 2'd0)
      begin
        rvalid_o = 1'b1;                // data follows mem_addr_o through the testbench.
        words_left = words_left - 1;
        if (words_left == 0)
        begin
          busy_q = 1'b0;
        end
        else
        begin
          wait_q = take_delay();
        end
      end
      else
      begin
        wait_q = wait_q - 2'd1;
      end
    end
  endtask

  initial
  begin
    lfsr_q = 16'd58977;
    busy_q = 1'b0;
    wait_q = 2'd0;
    words_left = 0;
    rvalid_o = 1'b0;
    next_ready_o = 1'b1;
    mem_addr_o = 32'd0;
    req_count_o = 0;
    forever
    begin
      @(posedge clk);
      #1;
      model_cycle();
      if (rvalid_o && words_left != 0)
      begin
        // second burst word comes from the next address.
        @(posedge clk);
        #1;
        mem_addr_o = mem_addr_o + 32'd4;
        model_cycle();
      end
    end
  end

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  import ifu_pkg::*;

  localparam int NROWS = 13;
  localparam int LIMIT = 300;           // cycles allowed for any single wait.

  logic        clk;
  logic        rst;
  logic [31:0] pc_i;
  logic        pc_valid;
  logic        pc_ready;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        next_ready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arburst;
  logic [31:0] rdata;
  logic        rvalid;
  logic [31:0] mem_addr;
  logic [31:0] mem_data;
  logic        bp_en;
  int          req_count;
  int          errors;
  int          timeouts;

  // start pc, offset of the control word, the control word, bus requests, back-pressure.
  logic [31:0] row_start [NROWS];
  logic [31:0] row_off [NROWS];
  logic [31:0] row_word [NROWS];
  int          row_req [NROWS];
  logic        row_bp [NROWS];

  fetch_top UUT (
    .clk, .rst, .pc_i, .pc_valid_i(pc_valid), .pc_ready_o(pc_ready),
    .inst_o, .pc_o, .valid_o, .next_ready_i(next_ready),
    .araddr_o(araddr), .arvalid_o(arvalid), .arburst_o(arburst),
    .rdata_i(rdata), .rvalid_i(rvalid)
  );

  bus_mem_model u_mem (
    .clk, .rst, .arvalid_i(arvalid), .araddr_i(araddr), .arburst_i(arburst),
    .rdata_o(rdata), .rvalid_o(rvalid), .mem_addr_o(mem_addr), .mem_data_i(mem_data),
    .bp_en_i(bp_en), .next_ready_o(next_ready), .req_count_o(req_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic set_row(input int r, input logic [31:0] start, input logic [31:0] off,
                         input logic [31:0] word, input int req, input logic bp);
    row_start[r] = start;
    row_off[r] = off;
    row_word[r] = word;
    row_req[r] = req;
    row_bp[r] = bp;
  endtask

  // ##########################################################################
  // memory contents and bus expectations
  // ##########################################################################

  // addi x1 with address bits as immediate and rs1, unless a control word sits there.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[13:2], addr[18:14], 3'b000, 5'd1, 7'b0010011};
    for (int i = 0; i < NROWS; i++)
    begin
      if (row_start[i] + row_off[i] == addr)
      begin
        w = row_word[i];
      end
    end
    return w;
  endfunction

  assign mem_data = word_at(mem_addr);

  function automatic logic in_burst_window(input logic [31:0] a);
    return (a >= BURST_LO) && (a <= BURST_HI);
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic finish_run();
    $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    timeouts++;
    $display("timeout while waiting for %s at %0t", what, $time);
  endtask

  // ##########################################################################
  // monitors sample on the falling edge
  // ##########################################################################

  logic        stall_q = 1'b0;
  logic [31:0] held_inst;
  logic [31:0] held_pc;
  logic        arvalid_q = 1'b0;
  logic        second_q = 1'b0;
  logic [31:0] base_q;

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (stall_q)
      begin
        assert (valid_o) else report_value("valid_o", 32'd1, {31'd0, valid_o});
        assert (inst_o == held_inst) else report_value("inst_o", held_inst, inst_o);
        assert (pc_o == held_pc) else report_value("pc_o", held_pc, pc_o);
      end
      stall_q = valid_o && !next_ready;
      held_inst = inst_o;
      held_pc = pc_o;
      if (arvalid && !arvalid_q)
      begin
        assert (arburst == in_burst_window({araddr[31:3], 3'b000}))
          else report_value("arburst_o", {31'd0, !arburst}, {31'd0, arburst});
        if (second_q)
        begin
          assert (araddr == base_q + 32'd4)
            else report_value("araddr_o", base_q + 32'd4, araddr);
          second_q = 1'b0;
        end
        else
        begin
          assert (araddr[2:0] == 3'b000)
            else report_value("araddr_o", {araddr[31:3], 3'b000}, araddr);
          second_q = !arburst;              // a single read is followed by base+4.
          base_q = araddr;
        end
      end
      arvalid_q = arvalid;
    end
  end

  // ##########################################################################
  // stimulus
  // ##########################################################################

  task automatic wait_pc_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!pc_ready && n < LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!pc_ready)
    begin
      give_up("pc_ready_o");
    end
  endtask

  task automatic wait_handoff();
    int n;
    n = 0;
    @(negedge clk);
    while (!(valid_o && next_ready) && n < LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!(valid_o && next_ready))
    begin
      give_up("a handoff to decode");
    end
  endtask

  task automatic run_row(input int r);
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    int          start_req;
    logic        done;
    wait_pc_ready();
    if (timeouts != 0)
    begin
      return;
    end
    start_req = req_count;
    bp_en = row_bp[r];
    @(posedge clk);
    #1;
    pc_i = row_start[r];
    pc_valid = 1'b1;
    @(posedge clk);
    #1;
    pc_valid = 1'b0;
    exp_pc = row_start[r];
    last_pc = row_start[r] + row_off[r];
    done = 1'b0;
    while (!done)
    begin
      wait_handoff();
      if (timeouts != 0)
      begin
        return;
      end
      assert (pc_o == exp_pc) else report_value("pc_o", exp_pc, pc_o);
      assert (inst_o == word_at(exp_pc)) else report_value("inst_o", word_at(exp_pc), inst_o);
      done = (exp_pc == last_pc);
      exp_pc = exp_pc + 32'd4;
      @(posedge clk);
    end
    @(negedge clk);
    bp_en = 1'b0;
    assert (pc_ready) else report_value("pc_ready_o", 32'd1, {31'd0, pc_ready});
    assert (req_count - start_req == row_req[r])
      else report_value("bus request count", row_req[r], req_count - start_req);
  endtask

  initial
  begin
    errors = 0;
    timeouts = 0;
    rst = 1'b1;
    pc_i = 32'd0;
    pc_valid = 1'b0;
    bp_en = 1'b0;
    set_row(0, 32'h0000_1000, 32'd12, {20'h00040, 5'd0, OP_JAL}, 4, 1'b0);
    set_row(1, 32'h0000_1000, 32'd12, {20'h00040, 5'd0, OP_JAL}, 0, 1'b0);
    set_row(2, 32'ha000_0010, 32'd8, {25'h0000400, OP_BRANCH}, 2, 1'b0);
    set_row(3, 32'h0000_1000, 32'd12, {20'h00040, 5'd0, OP_JAL}, 0, 1'b0);
    set_row(4, 32'h0000_2000, 32'd4, {12'd0, 5'd1, 3'b000, 5'd0, OP_JALR}, 2, 1'b0);
    set_row(5, 32'h0000_1000, 32'd12, {20'h00040, 5'd0, OP_JAL}, 2, 1'b0);
    set_row(6, 32'h0000_2000, 32'd4, {12'd0, 5'd1, 3'b000, 5'd0, OP_JALR}, 2, 1'b0);
    set_row(7, 32'h0000_3010, 32'd0, INST_FENCE_I, 2, 1'b0);
    set_row(8, 32'h0000_2000, 32'd4, {12'd0, 5'd1, 3'b000, 5'd0, OP_JALR}, 2, 1'b0);
    set_row(9, 32'hb000_0000, 32'd28, {25'd0, OP_SYSTEM}, 4, 1'b1);
    set_row(10, 32'hb000_0000, 32'd28, {25'd0, OP_SYSTEM}, 0, 1'b1);
    set_row(11, 32'h0000_4004, 32'd20, {20'h00080, 5'd0, OP_JAL}, 8, 1'b1);
    set_row(12, 32'hc000_0000, 32'd4, {20'h00100, 5'd0, OP_JAL}, 1, 1'b0);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (pc_ready) else report_value("pc_ready_o", 32'd1, {31'd0, pc_ready});
    assert (!valid_o) else report_value("valid_o", 32'd0, {31'd0, valid_o});
    assert (!arvalid) else report_value("arvalid_o", 32'd0, {31'd0, arvalid});
    for (int r = 0; r < NROWS && timeouts == 0; r++)
    begin
      run_row(r);
    end
    finish_run();
  end

endmodule

//--- fetch_top.f
common/ifu_pkg.sv
design/fetch_pc.sv
l1i/l1i_cache.sv
l1i/l1i_refill.sv
design/fetch_out.sv
design/fetch_top.sv
tests/bus_mem_model.sv
tests/fetch_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module fetch_tb -Mdir obj_dir -f fetch_top.f
	out="$$(./obj_dir/Vfetch_tb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
